/* rv_pipe.f */
+incdir+test
src/rv_pipe_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/sf_controller.sv
src/execute_stage.sv
src/mem_wb_stage.sv
src/rv_pipe_top.sv
test/rv_pipe_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the rv_pipe testbench with verilator

set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f rv_pipe.f \
    --top-module rv_pipe_tb \
    -Mdir obj_dir -o rv_pipe_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/rv_pipe_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
    exit 0
fi
exit 1

/* test/rv_pipe_prog.svh */
`ifndef RV_PIPE_PROG_SVH
`define RV_PIPE_PROG_SVH

// rv32i encoders with fields in isa order
function automatic logic [31:0] enc_r(input int f7, input int rs2, input int rs1,
                                      input int f3, input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
endfunction

function automatic logic [31:0] enc_i(input int imm, input int rs1, input int f3,
                                      input int rd, input logic [6:0] opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
endfunction

function automatic logic [31:0] enc_s(input int off, input int rs2, input int rs1);
    return {off[11:5], rs2[4:0], rs1[4:0], 3'b010, off[4:0], OPC_STORE};   // sw only
endfunction

function automatic logic [31:0] enc_b(input int off, input int rs2, input int rs1,
                                      input int f3);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], OPC_BRANCH};
endfunction

function automatic logic [31:0] enc_u(input int imm20, input int rd);
    return {imm20[19:0], rd[4:0], OPC_LUI};
endfunction

function automatic logic [31:0] enc_j(input int off, input int rd);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
endfunction

task automatic put(input logic [31:0] inst);
    rom[prog_len] = inst;
    prog_len++;
endtask

task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
endtask

task automatic build_program();
    for (int i = 0; i < ROM_WORDS; i++) begin
        rom[i] = NOP_WORD;                                   // addi x0, x0, 0
    end
    prog_len = 0;
    put(enc_i(256, 0, 0, 10, OPC_OP_IMM));                   // x10 = 0x100 as the store base
    put(enc_i(5, 0, 0, 1, OPC_OP_IMM));                      // x1 = 5
    put(enc_i(-3, 1, 0, 2, OPC_OP_IMM));                     // x2 = 2 with x1 forwarded from mem
    put(enc_r(0, 2, 1, 0, 3));                               // add x3 = 7 via the mem and wb paths
    put(enc_r(32, 3, 2, 0, 4));                              // sub x4 = 2 - 7
    put(enc_s(0, 3, 10));
    put(enc_s(4, 4, 10));
    put(enc_i(32'h401, 4, 5, 5, OPC_OP_IMM));                // srai x5 = -5 >>> 1 = -3
    put(enc_u(32'h12345, 6));                                // lui x6
    put(enc_r(0, 5, 6, 4, 7));                               // xor x7 = x6 ^ x5
    put(enc_s(8, 7, 10));
    put(enc_r(0, 1, 4, 2, 8));                               // slt -5 < 5 gives 1
    put(enc_r(0, 4, 1, 3, 9));                               // sltu 5 < 0xfffffffb gives 1
    put(enc_i(4, 8, 1, 11, OPC_OP_IMM));                     // slli x11 = 16
    put(enc_r(0, 9, 11, 6, 12));                             // or x12 = 16 | 1 = 0x11
    put(enc_s(12, 12, 10));
    put(enc_i(64, 0, 2, 13, OPC_LOAD));                      // lw x13 from 0x40
    put(enc_r(0, 1, 13, 0, 14));                             // load-use consumer
    put(enc_s(16, 14, 10));
    put(enc_b(8, 1, 1, 0));                                  // beq taken
    put(enc_s(40, 7, 10));                                   // poison
    put(enc_b(8, 2, 1, 1));                                  // bne taken
    put(enc_s(44, 7, 10));                                   // poison
    put(enc_b(8, 2, 1, 0));                                  // beq not taken
    put(enc_s(20, 1, 10));
    put(enc_b(8, 3, 3, 1));                                  // bne not taken
    put(enc_s(24, 2, 10));
    put(enc_j(8, 15));                                       // jal x15 skips one word
    put(enc_s(48, 7, 10));                                   // poison
    put(enc_s(28, 15, 10));
    put(enc_u(32'hace10, 16));
    put(enc_s(32, 16, 10));                                  // marker
    put(enc_j(0, 0));                                        // park on a self loop

    expect_store(32'h100, 32'h0000_0007);
    expect_store(32'h104, 32'hffff_fffb);
    expect_store(32'h108, 32'hedcb_affd);                    // 0x12345000 ^ 0xfffffffd
    expect_store(32'h10c, 32'h0000_0011);
    expect_store(32'h110, fill_word(32'h40) + 32'd5);
    expect_store(32'h114, 32'h0000_0005);
    expect_store(32'h118, 32'h0000_0002);
    expect_store(32'h11c, RESET_PC + 32'd112);               // jal sits at word 27
    expect_store(32'h120, 32'hace1_0000);                    // marker is last
endtask

`endif

/* test/rv_pipe_tb.sv */
`timescale 1ns/1ps

module rv_pipe_tb;
    import rv_pipe_pkg::*;

    localparam logic [31:0] RESET_PC  = 32'h0000_0080;
    localparam int          ROM_WORDS = 64;
    localparam logic [31:0] ROM_BYTES = 32'd256;
    localparam logic [31:0] NOP_WORD  = 32'h0000_0013;
    localparam int          MAX_CYCLES = 400;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic        dmem_we;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic [31:0] dmem_rdata;

    logic [31:0] rom [ROM_WORDS];
    int          prog_len;
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] ram [256];
    logic [31:0] rom_off;

    int          store_idx = 0;
    int          errors = 0;
    logic        marker_seen = 1'b0;
    logic        pc_checked = 1'b0;
    logic        timed_out = 1'b0;

    // initial ram word derived from the whole byte address
    function automatic logic [31:0] fill_word(input logic [31:0] byte_addr);
        return 32'h3c00_0000 + byte_addr * 32'h0000_1001;
    endfunction

`include "rv_pipe_prog.svh"

    rv_pipe_top #(.RESET_PC(RESET_PC)) DUT (
        .clk, .reset, .imem_addr, .imem_data, .dmem_we, .dmem_addr, .dmem_wdata, .dmem_rdata
    );

    always #5 clk = ~clk;

    // combinational rom answering nop outside the program window
    assign rom_off   = imem_addr - RESET_PC;
    assign imem_data = (rom_off < ROM_BYTES) ? rom[rom_off[7:2]] : NOP_WORD;

    assign dmem_rdata = ram[dmem_addr[9:2]];                 // 1 kB ram that wraps
    always @(posedge clk) begin
        if (dmem_we) begin
            ram[dmem_addr[9:2]] <= dmem_wdata;
        end
    end

    // compare one store against the next expected entry
    task automatic check_store();
        if (store_idx >= exp_addr.size()) begin
            $display("unexpected store past the end of the list at 0x%08h", dmem_addr);
            errors++;
        end else begin
            assert (dmem_addr == exp_addr[store_idx]) else begin
                $display("[FAIL] dmem_addr got 0x%08h expected 0x%08h (store %0d)",
                         dmem_addr, exp_addr[store_idx], store_idx);
                errors++;
            end
            assert (dmem_wdata == exp_data[store_idx]) else begin
                $display("[FAIL] dmem_wdata got 0x%08h expected 0x%08h (store %0d)",
                         dmem_wdata, exp_data[store_idx], store_idx);
                errors++;
            end
            if (store_idx == exp_addr.size() - 1) begin
                marker_seen = 1'b1;
            end
            store_idx++;
        end
    endtask

    // sample at the falling edge while dut outputs are stable
    always @(negedge clk) begin
        if (reset) begin
            assert (!dmem_we) else begin
                $display("store issued while reset is high");
                errors++;
            end
        end else begin
            if (!pc_checked) begin
                assert (imem_addr == RESET_PC) else begin
                    $display("[FAIL] imem_addr got 0x%08h expected 0x%08h",
                             imem_addr, RESET_PC);
                    errors++;
                end
                pc_checked = 1'b1;                           // first cycle out of reset only
            end
            if (dmem_we) begin
                check_store();
            end
        end
    end

    initial begin
        int cycles;
        build_program();
        for (int i = 0; i < 256; i++) begin
            ram[i] <= fill_word(32'(i) << 2);
        end
        repeat (10) @(posedge clk);
        #1 reset = 1'b0;

        cycles = 0;
        while (!marker_seen && cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (!marker_seen) begin
            timed_out = 1'b1;
            $display("timeout after %0d cycles waiting for the marker store", cycles);
        end
        repeat (4) @(posedge clk);                           // catch stray stores after marker

        $display("errors %0d, timeouts %0d, stores checked %0d of %0d",
                 errors, timed_out ? 1 : 0, store_idx, exp_addr.size());
        if (errors == 0 && !timed_out) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* src/rv_pipe_top.sv */
`timescale 1ns/1ps

module rv_pipe_top #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        reset,
    // instruction rom
    output logic [31:0] imem_addr,
    input  logic [31:0] imem_data,
    // data ram
    output logic        dmem_we,
    output logic [31:0] dmem_addr,
    output logic [31:0] dmem_wdata,
    input  logic [31:0] dmem_rdata
);
    import rv_pipe_pkg::*;

    if_id_t      if_id;
    id_ex_t      id_ex;
    ex_mem_t     ex_mem;
    wb_bus_t     wb;                 // to register file and exe forwarding
    wb_bus_t     mem_fwd;            // mem stage alu result
    logic [4:0]  id_rs1;
    logic [4:0]  id_rs2;
    logic        exe_load;
    logic [4:0]  exe_rd;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        if_en;
    logic        id_en;
    logic        id_flush;
    logic        exe_flush;

    fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
        .clk, .reset, .if_en, .id_en, .id_flush, .redirect, .redirect_pc,
        .imem_addr, .imem_data, .if_id
    );

    decode_stage u_decode (
        .clk, .reset, .id_flush, .exe_flush, .if_id, .wb, .id_rs1, .id_rs2, .id_ex
    );

    sf_controller u_sf_ctrl (
        .clk, .reset, .id_rs1, .id_rs2, .exe_load, .exe_rd, .redirect,
        .if_en, .id_en, .id_flush, .exe_flush
    );

    execute_stage u_execute (
        .clk, .reset, .id_ex, .mem_fwd, .wb, .exe_load, .exe_rd,
        .redirect, .redirect_pc, .ex_mem
    );

    mem_wb_stage u_mem_wb (
        .clk, .reset, .ex_mem, .dmem_we, .dmem_addr, .dmem_wdata, .dmem_rdata,
        .mem_fwd, .wb
    );

endmodule

/* src/mem_wb_stage.sv */
`timescale 1ns/1ps

module mem_wb_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  rv_pipe_pkg::ex_mem_t ex_mem,
    // data memory, answers in the same cycle
    output logic                 dmem_we,
    output logic [31:0]          dmem_addr,
    output logic [31:0]          dmem_wdata,
    input  logic [31:0]          dmem_rdata,
    // write-back and forwarding buses
    output rv_pipe_pkg::wb_bus_t mem_fwd,
    output rv_pipe_pkg::wb_bus_t wb
);
    import rv_pipe_pkg::*;

    logic [31:0] result;          // value headed for wb
    wb_bus_t     wb_q;

    assign dmem_we    = ex_mem.valid && ex_mem.mem_write;
    assign dmem_addr  = ex_mem.alu_result;    // word address in bytes
    assign dmem_wdata = ex_mem.store_data;

    // load data not ready for forwarding here, the hazard unit stalls instead
    assign mem_fwd.reg_write = ex_mem.valid && ex_mem.reg_write && !ex_mem.mem_read;
    assign mem_fwd.rd        = ex_mem.rd;
    assign mem_fwd.data      = ex_mem.alu_result;

    // word loads only
    assign result = (ex_mem.wb_src == WB_MEM) ? dmem_rdata : ex_mem.alu_result;

    // mem/wb register
    always_ff @(posedge clk) begin
        wb_q.rd   <= ex_mem.rd;
        wb_q.data <= result;
        if (reset) begin
            wb_q.reg_write <= 1'b0;
        end else begin
            wb_q.reg_write <= ex_mem.valid && ex_mem.reg_write;
        end
    end

    assign wb = wb_q;

    // store addresses come from the exe adder and forwarded base registers
    a_store_aligned : assert property (
        @(posedge clk) disable iff (reset) dmem_we |-> dmem_addr[1:0] == 2'b00
    ) else $error("store to unaligned address 0x%08h", dmem_addr);

endmodule

/* src/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  rv_pipe_pkg::id_ex_t  id_ex,
    input  rv_pipe_pkg::wb_bus_t mem_fwd,      // alu result in mem, loads excluded
    input  rv_pipe_pkg::wb_bus_t wb,           // value being written back
    output logic                 exe_load,
    output logic [4:0]           exe_rd,
    output logic                 redirect,     // combinational in exe
    output logic [31:0]          redirect_pc,
    output rv_pipe_pkg::ex_mem_t ex_mem
);
    import rv_pipe_pkg::*;

    logic [31:0] op_a;
    logic [31:0] op_b;                         // forwarded rs2, also the store data
    logic [31:0] alu_b;
    logic [31:0] alu_out;
    logic        equal;
    logic        taken;
    ex_mem_t     e;
    ex_mem_t     ex_mem_q;

    // newest producer wins, mem before wb before register file
    function automatic logic [31:0] fwd(input logic [4:0] rs, input logic [31:0] rf_val,
                                        input wb_bus_t m, input wb_bus_t w);
        if (rs != 5'd0 && m.reg_write && m.rd == rs) begin
            return m.data;
        end
        if (rs != 5'd0 && w.reg_write && w.rd == rs) begin
            return w.data;
        end
        return rf_val;
    endfunction

    assign op_a  = fwd(id_ex.rs1, id_ex.rs1_val, mem_fwd, wb);
    assign op_b  = fwd(id_ex.rs2, id_ex.rs2_val, mem_fwd, wb);
    assign alu_b = id_ex.use_imm ? id_ex.imm : op_b;

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD:    alu_out = op_a + alu_b;
            ALU_SUB:    alu_out = op_a - alu_b;
            ALU_AND:    alu_out = op_a & alu_b;
            ALU_OR:     alu_out = op_a | alu_b;
            ALU_XOR:    alu_out = op_a ^ alu_b;
            ALU_SLL:    alu_out = op_a << alu_b[4:0];
            ALU_SRL:    alu_out = op_a >> alu_b[4:0];
            ALU_SRA:    alu_out = $unsigned($signed(op_a) >>> alu_b[4:0]);
            ALU_SLT:    alu_out = {31'd0, $signed(op_a) < $signed(alu_b)};
            ALU_SLTU:   alu_out = {31'd0, op_a < alu_b};
            ALU_PASS_B: alu_out = alu_b;
            default:    alu_out = 32'd0;
        endcase
    end

    // branch compare uses the forwarded operands
    assign equal       = op_a == op_b;
    assign taken       = id_ex.is_branch && (id_ex.branch_ne ? !equal : equal);
    assign redirect    = id_ex.valid && (taken || id_ex.is_jal);
    assign redirect_pc = id_ex.pc + id_ex.imm;        // same adder for branch and jal

    assign exe_load = id_ex.valid && id_ex.mem_read;  // hazard unit input
    assign exe_rd   = id_ex.rd;

    always_comb begin
        e.valid      = id_ex.valid;
        e.alu_result = id_ex.is_jal ? id_ex.pc + 32'd4 : alu_out;   // jal links pc+4
        e.store_data = op_b;
        e.rd         = id_ex.rd;
        e.mem_read   = id_ex.mem_read;
        e.mem_write  = id_ex.mem_write;
        e.reg_write  = id_ex.reg_write;
        e.wb_src     = id_ex.wb_src;
    end

    // exe/mem register
    always_ff @(posedge clk) begin
        ex_mem_q <= e;
        if (reset) begin
            ex_mem_q.valid <= 1'b0;
        end
    end

    assign ex_mem = ex_mem_q;

endmodule

/* src/sf_controller.sv */
`timescale 1ns/1ps

module sf_controller (
    input  logic       clk,
    input  logic       reset,
    // id stage
    input  logic [4:0] id_rs1,        // zero when not read by the id instruction
    input  logic [4:0] id_rs2,
    // exe stage
    input  logic       exe_load,      // valid load sitting in exe
    input  logic [4:0] exe_rd,
    input  logic       redirect,      // taken branch or jal resolved in exe
    // stage controls
    output logic       if_en,         // pc register enable
    output logic       id_en,         // if/id register enable
    output logic       id_flush,      // clears if/id valid
    output logic       exe_flush      // clears id/exe valid
);

    /*
        load-use costs one bubble

        lw      IF  ID  EXE MEM WB
        add         IF  ID  ID  EXE MEM WB
                            ^ held here, load value forwarded from wb
    */

    logic load_use;
    logic stall;

    assign load_use = exe_load && exe_rd != 5'd0 &&
                      (id_rs1 == exe_rd || id_rs2 == exe_rd);
    assign stall    = load_use && !redirect;    // redirect kills the consumer anyway

    assign if_en     = !stall;
    assign id_en     = !stall;
    assign id_flush  = redirect;
    assign exe_flush = stall || redirect;       // bubble or squash into id/exe

    // after a stall the load has moved to mem and exe holds the bubble
    a_if_one_stall : assert property (
        @(posedge clk) disable iff (reset) !if_en |=> if_en
    ) else $error("if_en low for two cycles");

    a_id_one_stall : assert property (
        @(posedge clk) disable iff (reset) !id_en |=> id_en
    ) else $error("id_en low for two cycles");

    // stage valids are clear once reset has been seen at an edge
    a_reset_quiet : assert property (
        @(posedge clk) $past(reset) && reset |-> !id_flush && !exe_flush
    ) else $error("flush raised during reset");

endmodule

/* src/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 id_flush,    // redirect squashes the id instruction
    input  logic                 exe_flush,   // bubble into id/exe
    input  rv_pipe_pkg::if_id_t  if_id,
    input  rv_pipe_pkg::wb_bus_t wb,          // register file write port
    output logic [4:0]           id_rs1,      // to the hazard unit
    output logic [4:0]           id_rs2,
    output rv_pipe_pkg::id_ex_t  id_ex
);
    import rv_pipe_pkg::*;

    logic [31:0] rf [32];                     // x0 slot never written
    id_ex_t      d;
    id_ex_t      id_ex_q;
    logic        known;                       // opcode is in the supported subset
    logic        use_rs1;
    logic        use_rs2;
    logic        live;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    assign opcode = if_id.inst[6:0];
    assign funct3 = if_id.inst[14:12];
    assign funct7 = if_id.inst[31:25];

    assign imm_i = {{20{if_id.inst[31]}}, if_id.inst[31:20]};
    assign imm_s = {{20{if_id.inst[31]}}, if_id.inst[31:25], if_id.inst[11:7]};
    assign imm_b = {{19{if_id.inst[31]}}, if_id.inst[31], if_id.inst[7],
                    if_id.inst[30:25], if_id.inst[11:8], 1'b0};
    assign imm_u = {if_id.inst[31:12], 12'h000};
    assign imm_j = {{11{if_id.inst[31]}}, if_id.inst[31], if_id.inst[19:12],
                    if_id.inst[20], if_id.inst[30:21], 1'b0};

    function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    // write-before-read so wb data is seen in the same cycle
    function automatic logic [31:0] rf_read(input logic [4:0] idx, input logic [31:0] stored,
                                            input wb_bus_t w);
        if (idx == 5'd0) begin
            return 32'd0;
        end
        if (w.reg_write && w.rd == idx) begin
            return w.data;
        end
        return stored;
    endfunction

    always_comb begin
        d       = '0;
        d.pc    = if_id.pc;
        d.rd    = if_id.inst[11:7];
        d.imm   = imm_i;                      // i-type unless overridden
        known   = 1'b1;
        use_rs1 = 1'b1;
        use_rs2 = 1'b0;
        case (opcode)
            OPC_OP: begin
                d.alu_op    = alu_decode(funct3, funct7[5]);
                d.reg_write = 1'b1;
                use_rs2     = 1'b1;
            end
            OPC_OP_IMM: begin
                d.alu_op    = alu_decode(funct3, funct3 == 3'b101 && funct7[5]); // srai only
                d.use_imm   = 1'b1;
                d.reg_write = 1'b1;
            end
            OPC_LUI: begin
                d.alu_op    = ALU_PASS_B;
                d.imm       = imm_u;
                d.use_imm   = 1'b1;
                d.reg_write = 1'b1;
                use_rs1     = 1'b0;
            end
            OPC_LOAD: begin
                d.use_imm   = 1'b1;           // add base and offset
                d.mem_read  = 1'b1;
                d.reg_write = 1'b1;
                d.wb_src    = WB_MEM;
            end
            OPC_STORE: begin
                d.imm       = imm_s;
                d.use_imm   = 1'b1;
                d.mem_write = 1'b1;
                use_rs2     = 1'b1;
            end
            OPC_BRANCH: begin
                d.imm       = imm_b;
                d.is_branch = 1'b1;
                d.branch_ne = funct3[0];
                known       = funct3[2:1] == 2'b00;   // beq and bne only
                use_rs2     = 1'b1;
            end
            OPC_JAL: begin
                d.imm       = imm_j;
                d.is_jal    = 1'b1;
                d.reg_write = 1'b1;
                use_rs1     = 1'b0;
            end
            default: begin
                known   = 1'b0;               // unsupported word runs as a nop
                use_rs1 = 1'b0;
            end
        endcase
        live      = if_id.valid && !id_flush && known;
        d.valid   = live;
        d.rs1     = (live && use_rs1) ? if_id.inst[19:15] : 5'd0;
        d.rs2     = (live && use_rs2) ? if_id.inst[24:20] : 5'd0;
        d.rs1_val = rf_read(d.rs1, rf[d.rs1], wb);
        d.rs2_val = rf_read(d.rs2, rf[d.rs2], wb);
    end

    assign id_rs1 = d.rs1;
    assign id_rs2 = d.rs2;
    assign id_ex  = id_ex_q;

    always_ff @(posedge clk) begin
        if (wb.reg_write && wb.rd != 5'd0) begin
            rf[wb.rd] <= wb.data;
        end
    end

    // id/exe register, never held
    always_ff @(posedge clk) begin
        id_ex_q <= d;
        if (reset || exe_flush) begin
            id_ex_q.valid <= 1'b0;            // bubble
        end
    end

endmodule

/* src/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                if_en,        // low holds the pc on a load-use stall
    input  logic                id_en,        // low holds if/id
    input  logic                id_flush,     // squash the instruction being fetched
    input  logic                redirect,     // taken branch or jal in exe
    input  logic [31:0]         redirect_pc,
    output logic [31:0]         imem_addr,
    input  logic [31:0]         imem_data,    // combinational rom answer
    output rv_pipe_pkg::if_id_t if_id
);
    import rv_pipe_pkg::*;

    logic [31:0] pc_q;
    if_id_t      if_id_q;

    assign imem_addr = pc_q;
    assign if_id     = if_id_q;

    // program counter, redirect wins over the stall hold
    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= RESET_PC;
        end else if (redirect) begin
            pc_q <= redirect_pc;
        end else if (if_en) begin
            pc_q <= pc_q + 32'd4;                 // sequential fetch
        end
    end

    // if/id register
    always_ff @(posedge clk) begin
        if (id_en) begin
            if_id_q.pc    <= pc_q;
            if_id_q.inst  <= imem_data;
            if_id_q.valid <= 1'b1;
        end
        if (reset || id_flush) begin
            if_id_q.valid <= 1'b0;                // fetched word becomes a bubble
        end
    end

    // the redirect target comes from exe and must keep fetch word aligned
    a_fetch_aligned : assert property (
        @(posedge clk) disable iff (reset) imem_addr[1:0] == 2'b00
    ) else $error("fetch address 0x%08h not word aligned", imem_addr);

endmodule

/* src/rv_pipe_pkg.sv */
package rv_pipe_pkg;

    // alu function select, 4 bits wide
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLL    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_SLT    = 4'd8,
        ALU_SLTU   = 4'd9,
        ALU_PASS_B = 4'd10             // lui passes the u-immediate
    } alu_op_e;

    typedef enum logic {
        WB_ALU = 1'b0,                 // result comes from the alu
        WB_MEM = 1'b1                  // result comes from data memory
    } wb_src_e;

    // rv32i major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] inst;
    } if_id_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rs1;              // zero when the operand is not read
        logic [4:0]  rs2;
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
        logic [31:0] imm;
        logic [4:0]  rd;
        alu_op_e     alu_op;
        logic        use_imm;          // operand b from imm instead of rs2
        logic        is_branch;
        logic        branch_ne;        // bne when set, beq otherwise
        logic        is_jal;
        logic        mem_read;
        logic        mem_write;
        logic        reg_write;
        wb_src_e     wb_src;
    } id_ex_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] alu_result;       // also the memory address
        logic [31:0] store_data;
        logic [4:0]  rd;
        logic        mem_read;
        logic        mem_write;
        logic        reg_write;
        wb_src_e     wb_src;
    } ex_mem_t;

    typedef struct packed {
        logic        reg_write;
        logic [4:0]  rd;
        logic [31:0] data;
    } wb_bus_t;

endpackage
